// ==== hw/if_pkg.sv ====
//////////////////////////////
// Shared definitions for the instruction fetch stage
// Address widths, next-PC source encoding and the fetched-word record
// Imported by wildcard in the header of every RTL module
//////////////////////////////

`default_nettype none

package if_pkg;

  //////////////////////////////
  // Widths
  //////////////////////////////

  // Address and instruction width of the core
  parameter int XLEN = 32;

  // Upper part of mtvec that holds the trap base
  // The low 7 bits of a trap address come from the vector index
  parameter int MTVEC_W = 25;

  // Interrupt id used for vectored trap entry
  parameter int IRQ_ID_W = 5;

  //////////////////////////////
  // Next-PC source
  //////////////////////////////

  // Driven by the controller together with pc_set
  typedef enum logic [2:0] {
    PC_BOOT     = 3'd0,
    PC_JUMP     = 3'd1,
    PC_BRANCH   = 3'd2,
    PC_MRET     = 3'd3,
    PC_TRAP_EXC = 3'd4,
    PC_TRAP_IRQ = 3'd5
  } pc_mux_e;

  // One fetched word as it leaves the prefetch buffer
  // 65 bits, address in the top bits and error flag in bit 0
  typedef struct packed {
    logic [XLEN-1:0] addr;
    logic [XLEN-1:0] instr;
    logic            err;
  } fetch_entry_t;

endpackage

`default_nettype wire

// ==== hw/pc_select.sv ====
//////////////////////////////
// Next fetch address selection
// Purely combinational, sampled by the prefetcher on pc_set
// Also raises the mtvec init request on a boot redirect
//////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module pc_select import if_pkg::*; (
  // Source select from the controller
  input  pc_mux_e             pc_mux_i,
  input  logic                pc_set_i,
  // Candidate targets
  input  logic [XLEN-1:0]     boot_addr_i,
  input  logic [XLEN-1:0]     jump_target_i,
  input  logic [XLEN-1:0]     branch_target_i,
  input  logic [XLEN-1:0]     mepc_i,
  input  logic [MTVEC_W-1:0]  mtvec_addr_i,
  input  logic [IRQ_ID_W-1:0] irq_id_i,
  // Selected address and CSR side effect
  output logic [XLEN-1:0]     branch_addr_o,
  output logic                csr_mtvec_init_o
);

  always_comb begin
    // Boot address is word aligned here already
    branch_addr_o = {boot_addr_i[XLEN-1:2], 2'b00};
    case (pc_mux_i)
      PC_BOOT:     branch_addr_o = {boot_addr_i[XLEN-1:2], 2'b00};
      PC_JUMP:     branch_addr_o = jump_target_i;
      PC_BRANCH:   branch_addr_o = branch_target_i;
      // Return from trap handler
      PC_MRET:     branch_addr_o = mepc_i;
      // All exceptions share the trap base
      PC_TRAP_EXC: branch_addr_o = {mtvec_addr_i, {(XLEN - MTVEC_W){1'b0}}};
      // Interrupts are vectored, one word per id
      PC_TRAP_IRQ: branch_addr_o = {mtvec_addr_i, irq_id_i, 2'b00};
      default:     branch_addr_o = {boot_addr_i[XLEN-1:2], 2'b00};
    endcase
  end

  // CSR file loads mtvec from the boot address on the boot jump
  assign csr_mtvec_init_o = pc_set_i && (pc_mux_i == PC_BOOT);

endmodule

`default_nettype wire

// ==== hw/fetch_fifo.sv ====
//////////////////////////////
// Small synchronous FIFO for the fetch path
// Payload type is a parameter, used for addresses and fetched words
// Push and pop may share a cycle, flush empties it in one edge
//////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module fetch_fifo import if_pkg::*; #(
  // Power of two, at least 2
  parameter int  DEPTH   = 2,
  parameter type entry_t = fetch_entry_t
) (
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic                       flush_i,
  input  logic                       push_i,
  input  entry_t                     push_data_i,
  input  logic                       pop_i,
  output entry_t                     pop_data_o,
  output logic                       empty_o,
  output logic [$clog2(DEPTH+1)-1:0] count_o
);

  localparam int PTR_W = $clog2(DEPTH);
  localparam int CNT_W = $clog2(DEPTH + 1);

  entry_t           mem_q [DEPTH];
  logic [PTR_W-1:0] rd_ptr_q;
  logic [PTR_W-1:0] wr_ptr_q;
  logic [CNT_W-1:0] count_q;
  logic             full;
  logic             do_push;
  logic             do_pop;

  assign full    = (count_q == CNT_W'(DEPTH));
  // Pop on empty is ignored, push on full only when a slot frees up
  assign do_pop  = pop_i && (count_q != '0);
  assign do_push = push_i && (!full || do_pop);

  // Storage
  always_ff @(posedge clk) begin
    if (do_push) begin
      mem_q[wr_ptr_q] <= push_data_i;
    end
  end

  // Pointers wrap naturally since DEPTH is a power of two
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rd_ptr_q <= '0;
      wr_ptr_q <= '0;
      count_q  <= '0;
    end else if (flush_i) begin
      rd_ptr_q <= '0;
      wr_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (do_push) wr_ptr_q <= wr_ptr_q + PTR_W'(1);
      if (do_pop)  rd_ptr_q <= rd_ptr_q + PTR_W'(1);
      if (do_push && !do_pop) begin
        count_q <= count_q + CNT_W'(1);
      end else if (do_pop && !do_push) begin
        count_q <= count_q - CNT_W'(1);
      end
    end
  end

  // Head of the queue, valid only when not empty
  assign pop_data_o = mem_q[rd_ptr_q];
  assign empty_o    = (count_q == '0);
  assign count_o    = count_q;

endmodule

`default_nettype wire

// ==== hw/prefetch_unit.sv ====
//////////////////////////////
// Instruction prefetcher on an OBI style bus
// Issues pipelined word requests, tracks outstanding ones and
// buffers the returned words for the IF/ID register
//////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module prefetch_unit import if_pkg::*; #(
  parameter int FIFO_DEPTH = 2
) (
  input  logic            clk,
  input  logic            rst_n,
  // Redirect and flush
  input  logic            pc_set_i,
  input  logic [XLEN-1:0] branch_addr_i,
  input  logic            kill_i,
  // OBI instruction bus
  output logic            instr_req_o,
  output logic [XLEN-1:0] instr_addr_o,
  input  logic            instr_gnt_i,
  input  logic            instr_rvalid_i,
  input  logic [XLEN-1:0] instr_rdata_i,
  input  logic            instr_err_i,
  // Toward the IF/ID register
  output logic            fetch_valid_o,
  output fetch_entry_t    fetch_entry_o,
  input  logic            fetch_ready_i,
  output logic            busy_o
);

  localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

  logic             active_q;
  logic [XLEN-1:0]  fetch_addr_q;
  logic [CNT_W-1:0] discard_q;
  logic [CNT_W-1:0] discard_d;
  logic [CNT_W:0]   inflight_sum;
  logic [CNT_W+1:0] used_slots;
  logic             redirect;
  logic             grant;
  logic             resp_drop;
  logic             resp_keep;
  logic [XLEN-1:0]  resp_addr;
  logic             aq_empty;
  logic [CNT_W-1:0] aq_count;
  fetch_entry_t     resp_entry;
  logic             wb_empty;
  logic [CNT_W-1:0] wb_count;

  //////////////////////////////
  // Request issue
  //////////////////////////////

  assign redirect = pc_set_i || kill_i;

  // Outstanding (kept and dropped) plus buffered words bound the issue
  assign used_slots = (CNT_W+2)'(aq_count) + (CNT_W+2)'(discard_q) + (CNT_W+2)'(wb_count);

  // Nothing is fetched before the first redirect out of reset
  assign instr_req_o  = active_q && (used_slots < (CNT_W+2)'(FIFO_DEPTH));
  assign instr_addr_o = fetch_addr_q;
  assign grant        = instr_req_o && instr_gnt_i;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      active_q     <= 1'b0;
      fetch_addr_q <= '0;
    end else if (pc_set_i) begin
      active_q     <= 1'b1;
      fetch_addr_q <= {branch_addr_i[XLEN-1:2], 2'b00};
    end else if (grant) begin
      // Next sequential word
      fetch_addr_q <= fetch_addr_q + XLEN'(4);
    end
  end

  //////////////////////////////
  // Response tracking
  //////////////////////////////

  // Responses to requests issued before a redirect are thrown away
  assign resp_drop = instr_rvalid_i && (discard_q != '0);
  assign resp_keep = instr_rvalid_i && (discard_q == '0) && !aq_empty;

  // Everything still in flight after this edge becomes stale on a redirect
  assign inflight_sum = (CNT_W+1)'(discard_q) + (CNT_W+1)'(aq_count)
                      + (CNT_W+1)'(grant) - (CNT_W+1)'(instr_rvalid_i);

  always_comb begin
    discard_d = discard_q;
    if (redirect) begin
      discard_d = inflight_sum[CNT_W-1:0];
    end else if (resp_drop) begin
      discard_d = discard_q - CNT_W'(1);
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      discard_q <= '0;
    end else begin
      discard_q <= discard_d;
    end
  end

  // Addresses of requests whose response is still to be kept
  fetch_fifo #(
    .DEPTH   (FIFO_DEPTH),
    .entry_t (logic [XLEN-1:0])
  ) addr_queue_i (
    .clk         (clk),
    .rst_n       (rst_n),
    .flush_i     (redirect),
    .push_i      (grant),
    .push_data_i (fetch_addr_q),
    .pop_i       (resp_keep),
    .pop_data_o  (resp_addr),
    .empty_o     (aq_empty),
    .count_o     (aq_count)
  );

  //////////////////////////////
  // Word buffer
  //////////////////////////////

  assign resp_entry = '{addr: resp_addr, instr: instr_rdata_i, err: instr_err_i};

  fetch_fifo #(
    .DEPTH   (FIFO_DEPTH),
    .entry_t (fetch_entry_t)
  ) word_buf_i (
    .clk         (clk),
    .rst_n       (rst_n),
    .flush_i     (redirect),
    .push_i      (resp_keep),
    .push_data_i (resp_entry),
    .pop_i       (fetch_ready_i && !wb_empty),
    .pop_data_o  (fetch_entry_o),
    .empty_o     (wb_empty),
    .count_o     (wb_count)
  );

  assign fetch_valid_o = !wb_empty;
  // Busy while any bus transaction is in flight
  assign busy_o        = !aq_empty || (discard_q != '0);

endmodule

`default_nettype wire

// ==== hw/if_id_register.sv ====
//////////////////////////////
// IF/ID pipeline register
// Valid/ready hand-off to decode, frozen under back-pressure
// Intake blocked while halted, contents dropped on kill
//////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module if_id_register import if_pkg::*; (
  input  logic            clk,
  input  logic            rst_n,
  // From the prefetch buffer
  input  logic            fetch_valid_i,
  input  fetch_entry_t    fetch_entry_i,
  output logic            fetch_ready_o,
  // Stage controls
  input  logic            kill_i,
  input  logic            halt_i,
  // Toward decode
  output logic            id_valid_o,
  input  logic            id_ready_i,
  output logic [XLEN-1:0] id_pc_o,
  output logic [XLEN-1:0] id_instr_o,
  output logic            id_bus_err_o
);

  logic take;

  // Room when empty or when decode takes the current word this cycle
  assign fetch_ready_o = !kill_i && !halt_i && (!id_valid_o || id_ready_i);
  assign take          = fetch_valid_i && fetch_ready_o;

  //////////////////////////////
  // Valid flag
  //////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      id_valid_o <= 1'b0;
    end else if (kill_i) begin
      id_valid_o <= 1'b0;
    end else if (take) begin
      id_valid_o <= 1'b1;
    end else if (id_ready_i) begin
      // Word consumed, nothing new behind it
      id_valid_o <= 1'b0;
    end
  end

  // Payload only moves on intake, so it holds while stalled
  always_ff @(posedge clk) begin
    if (take) begin
      id_pc_o      <= fetch_entry_i.addr;
      id_instr_o   <= fetch_entry_i.instr;
      id_bus_err_o <= fetch_entry_i.err;
    end
  end

endmodule

`default_nettype wire

// ==== hw/if_stage.sv ====
//////////////////////////////
// Instruction fetch stage top level
// Address select, prefetcher on the OBI bus and IF/ID register
// FIFO_DEPTH sets the word buffer and the request window
//////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module if_stage import if_pkg::*; #(
  parameter int FIFO_DEPTH = 2
) (
  input  logic                clk,
  input  logic                rst_n,
  // Redirect request and targets
  input  pc_mux_e             pc_mux_i,
  input  logic                pc_set_i,
  input  logic [XLEN-1:0]     boot_addr_i,
  input  logic [XLEN-1:0]     jump_target_i,
  input  logic [XLEN-1:0]     branch_target_i,
  input  logic [XLEN-1:0]     mepc_i,
  input  logic [MTVEC_W-1:0]  mtvec_addr_i,
  input  logic [IRQ_ID_W-1:0] irq_id_i,
  // Stage controls
  input  logic                kill_if_i,
  input  logic                halt_if_i,
  // OBI instruction bus
  output logic                instr_req_o,
  output logic [XLEN-1:0]     instr_addr_o,
  input  logic                instr_gnt_i,
  input  logic                instr_rvalid_i,
  input  logic [XLEN-1:0]     instr_rdata_i,
  input  logic                instr_err_i,
  // Decode side
  output logic                id_valid_o,
  input  logic                id_ready_i,
  output logic [XLEN-1:0]     id_pc_o,
  output logic [XLEN-1:0]     id_instr_o,
  output logic                id_bus_err_o,
  // Status
  output logic                if_busy_o,
  output logic                csr_mtvec_init_o
);

  logic [XLEN-1:0] branch_addr;
  logic            fetch_valid;
  logic            fetch_ready;
  fetch_entry_t    fetch_entry;

  pc_select pc_select_i (
    .pc_mux_i         (pc_mux_i),
    .pc_set_i         (pc_set_i),
    .boot_addr_i      (boot_addr_i),
    .jump_target_i    (jump_target_i),
    .branch_target_i  (branch_target_i),
    .mepc_i           (mepc_i),
    .mtvec_addr_i     (mtvec_addr_i),
    .irq_id_i         (irq_id_i),
    .branch_addr_o    (branch_addr),
    .csr_mtvec_init_o (csr_mtvec_init_o)
  );

  // Kill also drops buffered and in-flight words
  prefetch_unit #(
    .FIFO_DEPTH (FIFO_DEPTH)
  ) prefetch_unit_i (
    .clk            (clk),
    .rst_n          (rst_n),
    .pc_set_i       (pc_set_i),
    .branch_addr_i  (branch_addr),
    .kill_i         (kill_if_i),
    .instr_req_o    (instr_req_o),
    .instr_addr_o   (instr_addr_o),
    .instr_gnt_i    (instr_gnt_i),
    .instr_rvalid_i (instr_rvalid_i),
    .instr_rdata_i  (instr_rdata_i),
    .instr_err_i    (instr_err_i),
    .fetch_valid_o  (fetch_valid),
    .fetch_entry_o  (fetch_entry),
    .fetch_ready_i  (fetch_ready),
    .busy_o         (if_busy_o)
  );

  if_id_register if_id_register_i (
    .clk           (clk),
    .rst_n         (rst_n),
    .fetch_valid_i (fetch_valid),
    .fetch_entry_i (fetch_entry),
    .fetch_ready_o (fetch_ready),
    .kill_i        (kill_if_i),
    .halt_i        (halt_if_i),
    .id_valid_o    (id_valid_o),
    .id_ready_i    (id_ready_i),
    .id_pc_o       (id_pc_o),
    .id_instr_o    (id_instr_o),
    .id_bus_err_o  (id_bus_err_o)
  );

endmodule

`default_nettype wire

// ==== test/if_stage_props.sv ====
//////////////////////////////
// Concurrent checks for the instruction fetch stage
// Bound to if_stage from the testbench, counts its own failures
//////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module if_stage_props import if_pkg::*; #(
  parameter int          FIFO_DEPTH = 2,
  parameter logic [31:0] DATA_KEY   = 32'h0,
  parameter logic [31:0] ERR_BASE   = 32'h0,
  parameter logic [31:0] ERR_LIMIT  = 32'h0
) (
  input logic                clk,
  input logic                rst_n,
  input pc_mux_e             pc_mux_i,
  input logic                pc_set_i,
  input logic [XLEN-1:0]     boot_addr_i,
  input logic [XLEN-1:0]     jump_target_i,
  input logic [XLEN-1:0]     branch_target_i,
  input logic [XLEN-1:0]     mepc_i,
  input logic [MTVEC_W-1:0]  mtvec_addr_i,
  input logic [IRQ_ID_W-1:0] irq_id_i,
  input logic                kill_if_i,
  input logic                halt_if_i,
  input logic                instr_req_o,
  input logic [XLEN-1:0]     instr_addr_o,
  input logic                instr_gnt_i,
  input logic                instr_rvalid_i,
  input logic                id_valid_o,
  input logic                id_ready_i,
  input logic [XLEN-1:0]     id_pc_o,
  input logic [XLEN-1:0]     id_instr_o,
  input logic                id_bus_err_o,
  input logic                if_busy_o,
  input logic                csr_mtvec_init_o
);

  int unsigned     fail_count = 0;
  int unsigned     outstanding_q;
  logic            accept;
  logic            seen_set_q;
  logic            expect_valid_q;
  logic [XLEN-1:0] expect_pc_q;
  logic [XLEN-1:0] target;

  // Decode takes a word in this cycle
  assign accept = id_valid_o && id_ready_i;

  // Reference next-PC rule per source
  always_comb begin
    case (pc_mux_i)
      PC_BOOT:     target = {boot_addr_i[XLEN-1:2], 2'b00};
      PC_JUMP:     target = jump_target_i;
      PC_BRANCH:   target = branch_target_i;
      PC_MRET:     target = mepc_i;
      PC_TRAP_EXC: target = {mtvec_addr_i, 7'b000_0000};
      PC_TRAP_IRQ: target = {mtvec_addr_i, irq_id_i, 2'b00};
      default:     target = '0;
    endcase
  end

  //////////////////////////////
  // Reference state
  //////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      seen_set_q     <= 1'b0;
      expect_valid_q <= 1'b0;
      expect_pc_q    <= '0;
      outstanding_q  <= 0;
    end else begin
      if (pc_set_i) seen_set_q <= 1'b1;
      // Redirect wins, a lone kill leaves the next pc unknown
      if (pc_set_i) begin
        expect_valid_q <= 1'b1;
        expect_pc_q    <= {target[XLEN-1:2], 2'b00};
      end else if (kill_if_i) begin
        expect_valid_q <= 1'b0;
      end else if (accept) begin
        expect_valid_q <= 1'b1;
        expect_pc_q    <= id_pc_o + 32'd4;
      end
      outstanding_q <= outstanding_q + 32'(instr_req_o && instr_gnt_i)
                     - 32'(instr_rvalid_i);
    end
  end

  //////////////////////////////
  // Checks
  //////////////////////////////

  a_instr: assert property (@(posedge clk) disable iff (!rst_n)
    accept |-> id_instr_o == (id_pc_o ^ DATA_KEY))
    else begin
      $error("error %0t id_instr_o %h expected %h", $time, $sampled(id_instr_o),
             $sampled(id_pc_o) ^ DATA_KEY);
      fail_count++;
    end

  a_bus_err: assert property (@(posedge clk) disable iff (!rst_n)
    accept |-> id_bus_err_o == (id_pc_o >= ERR_BASE && id_pc_o < ERR_LIMIT))
    else begin
      $error("error %0t id_bus_err_o %b expected %b", $time, $sampled(id_bus_err_o),
             $sampled(id_pc_o) >= ERR_BASE && $sampled(id_pc_o) < ERR_LIMIT);
      fail_count++;
    end

  // Covers both the redirect target and sequential flow
  a_pc: assert property (@(posedge clk) disable iff (!rst_n)
    accept && expect_valid_q |-> id_pc_o == expect_pc_q)
    else begin
      $error("error %0t id_pc_o %h expected %h", $time, $sampled(id_pc_o),
             $sampled(expect_pc_q));
      fail_count++;
    end

  a_mtvec_init: assert property (@(posedge clk) disable iff (!rst_n)
    csr_mtvec_init_o == (pc_set_i && pc_mux_i == PC_BOOT))
    else begin
      $error("error %0t csr_mtvec_init_o %b expected %b", $time,
             $sampled(csr_mtvec_init_o),
             $sampled(pc_set_i) && $sampled(pc_mux_i) == PC_BOOT);
      fail_count++;
    end

  a_hold: assert property (@(posedge clk) disable iff (!rst_n)
    id_valid_o && !id_ready_i && !kill_if_i |=>
      id_valid_o && $stable(id_pc_o) && $stable(id_instr_o) && $stable(id_bus_err_o))
    else begin
      $error("ID outputs changed at %0t while decode was stalled", $time);
      fail_count++;
    end

  a_kill: assert property (@(posedge clk) disable iff (!rst_n)
    kill_if_i |=> !id_valid_o)
    else begin
      $error("id_valid_o still high at %0t after a kill", $time);
      fail_count++;
    end

  a_halt: assert property (@(posedge clk) disable iff (!rst_n)
    halt_if_i && !id_valid_o |=> !id_valid_o)
    else begin
      $error("id_valid_o rose at %0t while the stage was halted", $time);
      fail_count++;
    end

  a_outstanding: assert property (@(posedge clk) disable iff (!rst_n)
    outstanding_q <= FIFO_DEPTH)
    else begin
      $error("error %0t outstanding requests %0d limit %0d", $time,
             $sampled(outstanding_q), FIFO_DEPTH);
      fail_count++;
    end

  // Busy tracks the requests still owed a response
  a_busy: assert property (@(posedge clk) disable iff (!rst_n)
    if_busy_o == (outstanding_q != 0))
    else begin
      $error("error %0t if_busy_o %b expected %b", $time, $sampled(if_busy_o),
             $sampled(outstanding_q) != 0);
      fail_count++;
    end

  // A redirect may move an ungranted request
  a_req_stable: assert property (@(posedge clk) disable iff (!rst_n)
    instr_req_o && !instr_gnt_i && !pc_set_i && !kill_if_i |=>
      instr_req_o && $stable(instr_addr_o))
    else begin
      $error("Bus request dropped or moved at %0t before its grant", $time);
      fail_count++;
    end

  a_idle: assert property (@(posedge clk) disable iff (!rst_n)
    !seen_set_q |-> !instr_req_o && !id_valid_o)
    else begin
      $error("Fetch activity at %0t before the first redirect", $time);
      fail_count++;
    end

endmodule

`default_nettype wire

// ==== test/tb_if_stage.sv ====
//////////////////////////////
// Testbench for the instruction fetch stage
// Random OBI memory model, random redirects, halts and back-pressure
// Checking is done by the bound assertion module
//////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module tb_if_stage import if_pkg::*; #(
  parameter int FIFO_DEPTH = 2
) ();

  localparam int          STIM_CYCLES    = 400;
  localparam int          TIMEOUT_CYCLES = 10 * STIM_CYCLES;
  // Memory rule of the bus model
  localparam logic [31:0] DATA_KEY       = 32'hA5C3_0F69;
  localparam logic [31:0] ERR_BASE       = 32'h0000_1000;
  localparam logic [31:0] ERR_LIMIT      = 32'h0000_1040;

  // Checkers use the same memory rule as the bus model
  bind if_stage if_stage_props #(
    .FIFO_DEPTH (FIFO_DEPTH),
    .DATA_KEY   (32'hA5C3_0F69),
    .ERR_BASE   (32'h0000_1000),
    .ERR_LIMIT  (32'h0000_1040)
  ) props_i (.*);

  logic                clk;
  logic                rst_n;
  pc_mux_e             pc_mux_i;
  logic                pc_set_i;
  logic [XLEN-1:0]     boot_addr_i;
  logic [XLEN-1:0]     jump_target_i;
  logic [XLEN-1:0]     branch_target_i;
  logic [XLEN-1:0]     mepc_i;
  logic [MTVEC_W-1:0]  mtvec_addr_i;
  logic [IRQ_ID_W-1:0] irq_id_i;
  logic                kill_if_i;
  logic                halt_if_i;
  logic                instr_req_o;
  logic [XLEN-1:0]     instr_addr_o;
  logic                instr_gnt_i;
  logic                instr_rvalid_i;
  logic [XLEN-1:0]     instr_rdata_i;
  logic                instr_err_i;
  logic                id_valid_o;
  logic                id_ready_i;
  logic [XLEN-1:0]     id_pc_o;
  logic [XLEN-1:0]     id_instr_o;
  logic                id_bus_err_o;
  logic                if_busy_o;
  logic                csr_mtvec_init_o;

  logic [XLEN-1:0]     pend_addr[$];
  int unsigned         pend_due[$];
  int unsigned         cyc;
  int unsigned         accepted;
  int unsigned         redirects;
  logic                stop_grant;
  integer              seed;

  if_stage #(
    .FIFO_DEPTH (FIFO_DEPTH)
  ) DUT (.*);

  always #20 clk = ~clk;

  // Cycle count for the timeout and words taken by decode
  always @(posedge clk) begin
    cyc <= cyc + 1;
    if (id_valid_o && id_ready_i) accepted <= accepted + 1;
  end

  //////////////////////////////
  // OBI memory model
  //////////////////////////////

  // Random grant, in-order response 1 to 3 cycles after the grant
  always @(posedge clk) begin
    logic [XLEN-1:0] addr;
    if (rst_n) begin
      instr_gnt_i <= !stop_grant && (($random(seed) & 3) != 0);
      if (instr_req_o && instr_gnt_i) begin
        pend_addr.push_back(instr_addr_o);
        pend_due.push_back(cyc + ($unsigned($random(seed)) % 3));
      end
      if (pend_due.size() != 0 && pend_due[0] <= cyc) begin
        addr = pend_addr.pop_front();
        void'(pend_due.pop_front());
        instr_rvalid_i <= 1'b1;
        instr_rdata_i  <= addr ^ DATA_KEY;
        instr_err_i    <= (addr >= ERR_BASE) && (addr < ERR_LIMIT);
      end else begin
        instr_rvalid_i <= 1'b0;
      end
    end
  end

  // Redirect from the given source together with a kill of the stage
  task automatic redirect(input pc_mux_e src);
    pc_mux_i        <= src;
    pc_set_i        <= 1'b1;
    kill_if_i       <= 1'b1;
    jump_target_i   <= 32'h0000_0F80 + ($random(seed) & 32'h0000_01FC);
    branch_target_i <= 32'h0000_0F80 + ($random(seed) & 32'h0000_01FC);
    mepc_i          <= 32'h0000_0F80 + ($random(seed) & 32'h0000_01FC);
    mtvec_addr_i    <= MTVEC_W'($random(seed));
    irq_id_i        <= IRQ_ID_W'($random(seed));
    redirects       = redirects + 1;
  endtask

  //////////////////////////////
  // Stimulus
  //////////////////////////////

  initial begin
    int unsigned halt_left;
    int unsigned pick;
    int unsigned errors;
    seed = 45458;
    clk = 1'b0;
    rst_n = 1'b0;
    pc_mux_i = PC_BOOT;
    pc_set_i = 1'b0;
    boot_addr_i = 32'h0000_0FC2;
    jump_target_i = '0;
    branch_target_i = '0;
    mepc_i = '0;
    mtvec_addr_i = '0;
    irq_id_i = '0;
    kill_if_i = 1'b0;
    halt_if_i = 1'b0;
    instr_gnt_i = 1'b0;
    instr_rvalid_i = 1'b0;
    instr_rdata_i = '0;
    instr_err_i = 1'b0;
    id_ready_i = 1'b0;
    cyc = 0;
    accepted = 0;
    redirects = 0;
    stop_grant = 1'b0;
    halt_left = 0;
    repeat (2) @(posedge clk);
    rst_n <= 1'b1;
    @(posedge clk);
    redirect(PC_BOOT);
    for (int i = 0; i < STIM_CYCLES; i++) begin
      @(posedge clk);
      pc_set_i   <= 1'b0;
      kill_if_i  <= 1'b0;
      id_ready_i <= (($random(seed) & 1) != 0);
      pick = $unsigned($random(seed)) % 32;
      // Short halts of 1 to 4 cycles
      if (halt_left != 0) begin
        halt_left = halt_left - 1;
      end else if (pick == 0) begin
        halt_left = 1 + $unsigned($random(seed)) % 4;
      end
      halt_if_i <= (halt_left != 0);
      if (i == STIM_CYCLES / 2) begin
        // Lone kill without a new target
        kill_if_i <= 1'b1;
      end else if (pick == 1 || pick == 2) begin
        redirect(pc_mux_e'(3'(1 + $unsigned($random(seed)) % 5)));
      end
    end
    // Stop new grants and let the bus drain
    @(posedge clk);
    pc_set_i   <= 1'b0;
    kill_if_i  <= 1'b0;
    halt_if_i  <= 1'b0;
    id_ready_i <= 1'b1;
    stop_grant <= 1'b1;
    while (pend_addr.size() != 0) @(posedge clk);
    repeat (3) @(posedge clk);
    errors = DUT.props_i.fail_count;
    $display("Checks failed: %0d, words accepted: %0d, redirects: %0d",
             errors, accepted, redirects);
    if (errors == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

  // Run limit
  initial begin
    wait (cyc >= TIMEOUT_CYCLES);
    $display("Timeout: the run did not end within %0d cycles", TIMEOUT_CYCLES);
    $display("Something failed");
    $finish;
  end

endmodule

`default_nettype wire

// ==== verilog.f ====
hw/if_pkg.sv
hw/pc_select.sv
hw/fetch_fifo.sv
hw/prefetch_unit.sv
hw/if_id_register.sv
hw/if_stage.sv
test/if_stage_props.sv
test/tb_if_stage.sv

// ==== Makefile ====
# Verilator build and run of the fetch stage testbench

SIM := obj_dir/Vtb_if_stage

.PHONY: all run clean

all: run

# Rebuilt only when a source or the file list changes
$(SIM): verilog.f $(wildcard hw/*.sv test/*.sv)
	verilator --binary --timing --assert --top-module tb_if_stage -f verilog.f

run: $(SIM)
	$(SIM) +verilator+error+limit+1000 | tee sim.log
	@if grep -q "Something failed" sim.log; then echo "Simulation FAILED"; exit 1; fi
	@grep -q "Everything OK" sim.log || (echo "Simulation did not complete"; exit 1)

clean:
	rm -rf obj_dir sim.log
